// ==== src/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// number of words in the array.
`define MEM_DEPTH 64

// address width, covers MEM_DEPTH.
`define MEM_ADDR_BITS 6

// data word width.
`define MEM_WIDTH 16

// index into one data word.
`define MEM_BIT_SEL_BITS 4

// array read delay in cycles, at least 1.
`define MEM_SRAM_DELAY 1

`endif

// ==== src/mem_pkg.sv ====
package mem_pkg;

  `include "mem_config.svh"

  // logical read request.
  typedef struct packed {
    logic                      rd;
    logic [`MEM_ADDR_BITS-1:0] addr;
  } rd_req_t;

  // logical write request, mask is per data bit.
  typedef struct packed {
    logic                      wr;
    logic [`MEM_ADDR_BITS-1:0] addr;
    logic [`MEM_WIDTH-1:0]     data;
    logic [`MEM_WIDTH-1:0]     mask;
  } wr_req_t;

  // read result with valid pulse.
  typedef struct packed {
    logic                  vld;
    logic [`MEM_WIDTH-1:0] data;
  } rd_rsp_t;

  // physical write port A, registered copy of a write request.
  typedef wr_req_t phy_wr_t;

  // physical read port B or C.
  // returned data comes back on its own bank output.
  typedef struct packed {
    logic                      rd;
    logic [`MEM_ADDR_BITS-1:0] addr;
  } phy_rd_t;

endpackage

// ==== src/mem_input_stage.sv ====
`timescale 1ns/100ps

`include "mem_config.svh"

module mem_input_stage
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  rd_req_t    rd_req [2],
  input  wr_req_t    wr_req,
  output phy_wr_t    phy_a,
  output phy_rd_t    phy_b,
  output phy_rd_t    phy_c,
  output logic [1:0] rd_pend
);

  phy_wr_t a_q;
  phy_rd_t b_q;
  phy_rd_t c_q;

  // payload loads every cycle, only the strobes see reset.
  always_ff @(posedge clk) begin
    a_q.addr <= wr_req.addr;
    a_q.data <= wr_req.data;
    a_q.mask <= wr_req.mask;
    b_q.addr <= rd_req[0].addr;
    c_q.addr <= rd_req[1].addr;
    if (rst) begin
      a_q.wr <= 1'b0;
      b_q.rd <= 1'b0;
      c_q.rd <= 1'b0;
    end else begin
      a_q.wr <= wr_req.wr;
      b_q.rd <= rd_req[0].rd;
      c_q.rd <= rd_req[1].rd;
    end
  end

  // read 0 goes to B, read 1 to C.
  assign phy_a = a_q;
  assign phy_b = b_q;
  assign phy_c = c_q;

  // pending reads, aligned with the physical read strobes.
  assign rd_pend = {c_q.rd, b_q.rd};

  a_addr_range: assert property (@(posedge clk) disable iff (rst)
    (a_q.wr |-> (a_q.addr < `MEM_DEPTH)) and
    (b_q.rd |-> (b_q.addr < `MEM_DEPTH)) and
    (c_q.rd |-> (c_q.addr < `MEM_DEPTH)));

endmodule

// ==== src/mem_sram_bank.sv ====
`timescale 1ns/100ps

`include "mem_config.svh"

module mem_sram_bank
  import mem_pkg::*;
(
  input  logic                  clk,
  input  phy_wr_t               phy_a,
  input  phy_rd_t               phy_b,
  input  phy_rd_t               phy_c,
  output logic [`MEM_WIDTH-1:0] dout_b,
  output logic [`MEM_WIDTH-1:0] dout_c
);

  localparam int DELAY = `MEM_SRAM_DELAY;

  logic [`MEM_WIDTH-1:0] mem_q [`MEM_DEPTH];

  // read ports as one array, B first.
  phy_rd_t               rd_port [2];
  logic [`MEM_WIDTH-1:0] rd_dly  [2][DELAY];

  assign rd_port[0] = phy_b;
  assign rd_port[1] = phy_c;

  // masked write, unmasked bits keep their old value.
  always_ff @(posedge clk) begin
    if (phy_a.wr) begin
      mem_q[phy_a.addr] <= (mem_q[phy_a.addr] & ~phy_a.mask) |
                           (phy_a.data & phy_a.mask);
    end
  end

  // reads sample the array before a write at the same edge.
  for (genvar p = 0; p < 2; p++) begin : g_rd
    always_ff @(posedge clk) begin
      if (rd_port[p].rd) begin
        rd_dly[p][0] <= mem_q[rd_port[p].addr];
      end
      for (int i = 1; i < DELAY; i++) begin
        rd_dly[p][i] <= rd_dly[p][i-1];
      end
    end
  end

  assign dout_b = rd_dly[0][DELAY-1];
  assign dout_c = rd_dly[1][DELAY-1];

endmodule

// ==== src/mem_output_stage.sv ====
`timescale 1ns/100ps

`include "mem_config.svh"

module mem_output_stage
  import mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [1:0]            rd_pend,
  input  logic [`MEM_WIDTH-1:0] dout_b,
  input  logic [`MEM_WIDTH-1:0] dout_c,
  output rd_rsp_t               rd_rsp [2]
);

  localparam int DELAY = `MEM_SRAM_DELAY;

  logic [1:0]            pend_dly [DELAY];
  logic [`MEM_WIDTH-1:0] dout     [2];
  rd_rsp_t               rsp_q    [2];

  assign dout[0] = dout_b;
  assign dout[1] = dout_c;

  // strobe delay line, matches the array delay.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DELAY; i++) begin
        pend_dly[i] <= 2'b00;
      end
    end else begin
      pend_dly[0] <= rd_pend;
      for (int i = 1; i < DELAY; i++) begin
        pend_dly[i] <= pend_dly[i-1];
      end
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_rsp
    always_ff @(posedge clk) begin
      rsp_q[p].data <= dout[p];
      if (rst) begin
        rsp_q[p].vld <= 1'b0;
      end else begin
        rsp_q[p].vld <= pend_dly[DELAY-1][p];
      end
    end
    assign rd_rsp[p] = rsp_q[p];
  end

  // nothing can come out before a full trip through the pipeline.
  a_no_early_vld: assert property (@(posedge clk)
    $fell(rst) |-> (!rsp_q[0].vld && !rsp_q[1].vld) [*(DELAY + 2)]);

endmodule

// ==== src/mem_2r1w_checker.sv ====
`timescale 1ns/100ps

`include "mem_config.svh"

module mem_2r1w_checker
  import mem_pkg::*;
(
  input logic                         clk,
  input logic                         rst,
  input rd_req_t                      rd_req [2],
  input wr_req_t                      wr_req,
  input rd_rsp_t                      rd_rsp [2],
  input phy_wr_t                      phy_a,
  input phy_rd_t                      phy_b,
  input phy_rd_t                      phy_c,
  input logic [`MEM_WIDTH-1:0]        dout_b,
  input logic [`MEM_WIDTH-1:0]        dout_c,
  input logic [`MEM_ADDR_BITS-1:0]    select_addr,
  input logic [`MEM_BIT_SEL_BITS-1:0] select_bit
);

  localparam int DELAY = `MEM_SRAM_DELAY;
  localparam int LAT   = `MEM_SRAM_DELAY + 2;

  logic phy_inv;
  logic phy_bit;
  logic log_inv;
  logic log_bit;

  logic phy_hit;
  logic log_hit;

  assign phy_hit = phy_a.wr && phy_a.mask[select_bit] && (phy_a.addr == select_addr);
  assign log_hit = wr_req.wr && wr_req.mask[select_bit] && (wr_req.addr == select_addr);

  // shadow of the watched bit as seen on port A.
  always_ff @(posedge clk) begin
    if (rst) begin
      phy_inv <= 1'b1;
    end else if (phy_hit) begin
      phy_inv <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (phy_hit) begin
      phy_bit <= phy_a.data[select_bit];
    end
  end

  // same bit as seen at the logical write request.
  always_ff @(posedge clk) begin
    if (rst) begin
      log_inv <= 1'b1;
    end else if (log_hit) begin
      log_inv <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (log_hit) begin
      log_bit <= wr_req.data[select_bit];
    end
  end

  a_phy_dout_b: assert property (@(posedge clk) disable iff (rst)
    (phy_b.rd && (phy_b.addr == select_addr)) |-> ##DELAY
    ($past(phy_inv, DELAY) || (dout_b[select_bit] == $past(phy_bit, DELAY))));

  a_phy_dout_c: assert property (@(posedge clk) disable iff (rst)
    (phy_c.rd && (phy_c.addr == select_addr)) |-> ##DELAY
    ($past(phy_inv, DELAY) || (dout_c[select_bit] == $past(phy_bit, DELAY))));

  // port A trails the logical write by the input register.
  a_shadow_match: assert property (@(posedge clk) disable iff (rst)
    !$past(log_inv) |-> (!phy_inv && (phy_bit == $past(log_bit))));

  for (genvar p = 0; p < 2; p++) begin : g_rd
    a_rd_dout: assert property (@(posedge clk) disable iff (rst)
      (rd_req[p].rd && (rd_req[p].addr == select_addr)) |-> ##LAT
      ($past(log_inv, LAT) ||
       (rd_rsp[p].vld && (rd_rsp[p].data[select_bit] == $past(log_bit, LAT)))));
  end

endmodule

// ==== src/mem_2r1w_top.sv ====
`timescale 1ns/100ps

`include "mem_config.svh"

module mem_2r1w_top
  import mem_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  rd_req_t                      rd_req [2],
  input  wr_req_t                      wr_req,
  output rd_rsp_t                      rd_rsp [2],
  input  logic [`MEM_ADDR_BITS-1:0]    select_addr,
  input  logic [`MEM_BIT_SEL_BITS-1:0] select_bit
);

  phy_wr_t               phy_a;
  phy_rd_t               phy_b;
  phy_rd_t               phy_c;
  logic [1:0]            rd_pend;
  logic [`MEM_WIDTH-1:0] dout_b;
  logic [`MEM_WIDTH-1:0] dout_c;

  mem_input_stage input_i (
    .clk     (clk),
    .rst     (rst),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .phy_a   (phy_a),
    .phy_b   (phy_b),
    .phy_c   (phy_c),
    .rd_pend (rd_pend)
  );

  mem_sram_bank bank_i (
    .clk    (clk),
    .phy_a  (phy_a),
    .phy_b  (phy_b),
    .phy_c  (phy_c),
    .dout_b (dout_b),
    .dout_c (dout_c)
  );

  mem_output_stage output_i (
    .clk     (clk),
    .rst     (rst),
    .rd_pend (rd_pend),
    .dout_b  (dout_b),
    .dout_c  (dout_c),
    .rd_rsp  (rd_rsp)
  );

  mem_2r1w_checker checker_i (
    .clk         (clk),
    .rst         (rst),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .rd_rsp      (rd_rsp),
    .phy_a       (phy_a),
    .phy_b       (phy_b),
    .phy_c       (phy_c),
    .dout_b      (dout_b),
    .dout_c      (dout_c),
    .select_addr (select_addr),
    .select_bit  (select_bit)
  );

endmodule

// ==== testbench/tb_mem_2r1w.sv ====
`timescale 1ns/100ps

`include "mem_config.svh"

module tb_mem_2r1w
  import mem_pkg::*;
();

  localparam int LAT          = `MEM_SRAM_DELAY + 2;
  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 16;
  localparam int SEED         = 71;
  localparam int MARGIN       = 100;

  // one cycle of stimulus.
  typedef struct packed {
    wr_req_t w;
    rd_req_t r0;
    rd_req_t r1;
  } op_t;

  // expected responses for one cycle, care marks bits known to the model.
  typedef struct packed {
    rd_rsp_t               rsp0;
    rd_rsp_t               rsp1;
    logic [`MEM_WIDTH-1:0] care0;
    logic [`MEM_WIDTH-1:0] care1;
  } exp_t;

  logic                         clk;
  logic                         rst;
  rd_req_t                      rd_req [2];
  wr_req_t                      wr_req;
  rd_rsp_t                      rd_rsp [2];
  logic [`MEM_ADDR_BITS-1:0]    select_addr;
  logic [`MEM_BIT_SEL_BITS-1:0] select_bit;

  op_t                   ops [$];
  exp_t                  exp_q [$];
  logic [`MEM_WIDTH-1:0] ref_mem  [`MEM_DEPTH];
  logic [`MEM_WIDTH-1:0] ref_seen [`MEM_DEPTH];
  wr_req_t               prev_wr;
  int                    cycles;
  int                    limit;
  int                    n_rsp;

  mem_2r1w_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .rd_rsp      (rd_rsp),
    .select_addr (select_addr),
    .select_bit  (select_bit)
  );

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_rsp(input string name, input rd_rsp_t got, input rd_rsp_t exp,
                           input logic [`MEM_WIDTH-1:0] care);
    if (got.vld !== exp.vld) begin
      stop_on_error($sformatf("Fail at %0t: %s.vld got %b, expected %b",
                              $time, name, got.vld, exp.vld));
    end
    if (exp.vld && ((got.data & care) !== (exp.data & care))) begin
      stop_on_error($sformatf("Fail at %0t: %s.data got %h, expected %h (known bits %h)",
                              $time, name, got.data, exp.data, care));
    end
    if (exp.vld) begin
      n_rsp++;
    end
  endtask

  // port A must echo last cycle's write request.
  task automatic check_wr(input string name, input wr_req_t got, input wr_req_t exp);
    if ((got.wr !== exp.wr) || (exp.wr && (got !== exp))) begin
      stop_on_error($sformatf("Fail at %0t: %s got %h, expected %h",
                              $time, name, got, exp));
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    int          sa;
    int          sb;
    int          f_wr, f_wa, f_wd, f_wm, f_r0, f_a0, f_r1, f_a1, rep;
    string       line;
    op_t         op;
    op_t         lim;
    logic [63:0] rnd;
    fd = $fopen("testbench/mem_cases.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open the case file testbench/mem_cases.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) == "S") begin
        n = $sscanf(line, "S %h %h", sa, sb);
        if (n != 2) begin
          stop_on_error({"malformed select line in case file: ", line});
        end
        select_addr = sa[`MEM_ADDR_BITS-1:0];
        select_bit  = sb[`MEM_BIT_SEL_BITS-1:0];
      end else if (n > 0 && line.getc(0) == "O") begin
        n = $sscanf(line, "O %h %h %h %h %h %h %h %h %d",
                    f_wr, f_wa, f_wd, f_wm, f_r0, f_a0, f_r1, f_a1, rep);
        if (n != 9) begin
          stop_on_error({"malformed operation line in case file: ", line});
        end
        lim.w.wr    = f_wr[0];
        lim.w.addr  = f_wa[`MEM_ADDR_BITS-1:0];
        lim.w.data  = f_wd[`MEM_WIDTH-1:0];
        lim.w.mask  = f_wm[`MEM_WIDTH-1:0];
        lim.r0.rd   = f_r0[0];
        lim.r0.addr = f_a0[`MEM_ADDR_BITS-1:0];
        lim.r1.rd   = f_r1[0];
        lim.r1.addr = f_a1[`MEM_ADDR_BITS-1:0];
        for (int i = 0; i < rep; i++) begin
          // random fields are masked by the values on the line.
          if (rep > 1) begin
            rnd = {$urandom(), $urandom()};
            op  = rnd[$bits(op_t)-1:0] & lim;
          end else begin
            op = lim;
          end
          ops.push_back(op);
        end
      end
    end
    $fclose(fd);
  endtask

  // reads see the model before this cycle's write lands.
  task automatic drive_op(input op_t op);
    exp_t e;
    e = '0;
    if (op.r0.rd) begin
      e.rsp0.vld  = 1'b1;
      e.rsp0.data = ref_mem[op.r0.addr];
      e.care0     = ref_seen[op.r0.addr];
    end
    if (op.r1.rd) begin
      e.rsp1.vld  = 1'b1;
      e.rsp1.data = ref_mem[op.r1.addr];
      e.care1     = ref_seen[op.r1.addr];
    end
    exp_q.push_back(e);
    if (op.w.wr) begin
      for (int b = 0; b < `MEM_WIDTH; b++) begin
        if (op.w.mask[b]) begin
          ref_mem[op.w.addr][b]  = op.w.data[b];
          ref_seen[op.w.addr][b] = 1'b1;
        end
      end
    end
    rd_req[0] = op.r0;
    rd_req[1] = op.r1;
    wr_req    = op.w;
  endtask

  task automatic run_cycle(input op_t op);
    exp_t e;
    @(posedge clk);
    #1;
    e = exp_q.pop_front();
    check_rsp("rd_rsp[0]", rd_rsp[0], e.rsp0, e.care0);
    check_rsp("rd_rsp[1]", rd_rsp[1], e.rsp1, e.care1);
    check_wr("phy_a", dut_i.phy_a, prev_wr);
    #1;
    drive_op(op);
    prev_wr = op.w;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  initial begin
    int unsigned seed_val;
    exp_t        idle;
    seed_val    = $urandom(SEED);
    rst         = 1'b1;
    rd_req[0]   = '0;
    rd_req[1]   = '0;
    wr_req      = '0;
    select_addr = '0;
    select_bit  = '0;
    prev_wr     = '0;
    cycles      = 0;
    limit       = 0;
    n_rsp       = 0;
    idle        = '0;
    for (int a = 0; a < `MEM_DEPTH; a++) begin
      ref_mem[a]  = '0;
      ref_seen[a] = '0;
    end
    load_cases();
    limit = RESET_CYCLES + ops.size() + LAT + MARGIN;
    // valid stays low while reset is held.
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_rsp("rd_rsp[0]", rd_rsp[0], idle.rsp0, idle.care0);
      check_rsp("rd_rsp[1]", rd_rsp[1], idle.rsp1, idle.care1);
    end
    #1;
    rst = 1'b0;
    for (int i = 0; i < LAT; i++) begin
      exp_q.push_back(idle);
    end
    while (ops.size() > 0) begin
      run_cycle(ops.pop_front());
    end
    // drain the pipeline.
    repeat (LAT) begin
      run_cycle('0);
    end
    if (n_rsp > 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stop_on_error("no read response was checked during the run");
    end
  end

endmodule

// ==== testbench/mem_cases.txt ====
# S lines: checker address, checker bit. O lines: wr wr_addr wr_data wr_mask rd0 rd0_addr rd1 rd1_addr repeat
# hex fields, decimal repeat; with repeat > 1 each field is random, masked by the value given.
S 05 3
O 1 05 a5c3 ffff 0 00 0 00 1
O 0 00 0000 0000 1 05 1 05 1
O 1 05 1234 00ff 0 00 0 00 1
O 0 00 0000 0000 1 05 1 05 1
O 1 10 1111 ffff 1 3f 0 00 1
O 1 11 2222 ffff 0 00 1 3e 1
O 1 12 3333 ffff 0 00 0 00 1
O 0 00 0000 0000 1 10 1 11 1
O 0 00 0000 0000 1 12 1 05 1
O 0 00 0000 0000 1 11 1 10 1
O 1 05 0f0f ffff 1 05 0 00 1
O 0 00 0000 0000 0 00 1 05 1
O 1 07 ffff ffff 1 07 1 07 200

// ==== sources.f ====
+incdir+src
src/mem_pkg.sv
src/mem_input_stage.sv
src/mem_sram_bank.sv
src/mem_output_stage.sv
src/mem_2r1w_checker.sv
src/mem_2r1w_top.sv
testbench/tb_mem_2r1w.sv

// ==== Bender.yml ====
package:
  name: mem_2r1w

sources:
  - include_dirs:
      - src
    files:
      - src/mem_pkg.sv
      - src/mem_input_stage.sv
      - src/mem_sram_bank.sv
      - src/mem_output_stage.sv
      - src/mem_2r1w_checker.sv
      - src/mem_2r1w_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_mem_2r1w.sv
